/* mapGeometryPkg.sv */
/*
 * Map geometry for the route display.
 * Station centres, rail link boxes and the panel regions,
 * plus the small helpers that test a pixel against them.
 */
package mapGeometryPkg;

    localparam int coordWidth   = 10;
    localparam int stationCount = 16;
    localparam int linkCount    = 16;

    typedef logic [coordWidth-1:0] coord_t;
    typedef logic [4:0]            stationId_t;   // 0 = none, 1..16 = station
    typedef logic [linkCount-1:0]  routeMask_t;   // Bit k enables link k

    // Inclusive screen rectangle
    typedef struct packed {
        coord_t xLo;
        coord_t xHi;
        coord_t yLo;
        coord_t yHi;
    } box_t;

    // ------------------------------
    // Stations
    // ------------------------------
    localparam coord_t pickRadius   = 10'd1;
    localparam coord_t markerRadius = 10'd1;

    // Harbin, Changchun, Shenyang, Beijing, Tianjin, Dezhou, Jinan, Qingdao,
    // Nanjing, Shanghai, Hangzhou, Hefei, Nanchang, Wuhan, Changsha, Guangzhou
    localparam coord_t stationX [1:stationCount] = '{
        10'd569, 10'd563, 10'd547, 10'd465, 10'd478, 10'd478, 10'd489, 10'd527,
        10'd498, 10'd530, 10'd520, 10'd478, 10'd463, 10'd434, 10'd420, 10'd426
    };
    localparam coord_t stationY [1:stationCount] = '{
        10'd97,  10'd125, 10'd160, 10'd186, 10'd199, 10'd219, 10'd229, 10'd235,
        10'd286, 10'd301, 10'd311, 10'd297, 10'd334, 10'd311, 10'd340, 10'd407
    };

    // ------------------------------
    // Rail links
    // ------------------------------
    localparam box_t unusedBox = '{10'd0, 10'd0, 10'd0, 10'd0};

    localparam box_t linkBoxA [linkCount] = '{
        '{10'd563, 10'd569, 10'd97,  10'd125},   // Harbin - Changchun
        '{10'd547, 10'd563, 10'd125, 10'd160},   // Changchun - Shenyang
        '{10'd497, 10'd545, 10'd153, 10'd160},   // Shenyang - Beijing
        '{10'd465, 10'd478, 10'd188, 10'd199},   // Beijing - Tianjin
        '{10'd477, 10'd479, 10'd199, 10'd219},   // Tianjin - Dezhou
        '{10'd478, 10'd489, 10'd219, 10'd229},   // Dezhou - Jinan
        '{10'd492, 10'd520, 10'd228, 10'd230},   // Jinan - Qingdao
        '{10'd491, 10'd511, 10'd231, 10'd284},   // Jinan - Nanjing
        '{10'd501, 10'd529, 10'd285, 10'd299},   // Nanjing - Shanghai
        '{10'd521, 10'd529, 10'd302, 10'd311},   // Shanghai - Hangzhou
        '{10'd480, 10'd496, 10'd287, 10'd296},   // Hefei - Nanjing
        '{10'd496, 10'd518, 10'd308, 10'd311},   // Hefei - Hangzhou
        '{10'd463, 10'd477, 10'd301, 10'd332},   // Nanchang - Hefei
        '{10'd436, 10'd464, 10'd311, 10'd332},   // Nanchang - Wuhan
        '{10'd421, 10'd432, 10'd313, 10'd338},   // Wuhan - Changsha
        '{10'd420, 10'd428, 10'd357, 10'd405}    // Guangzhou - Changsha
    };

    // Second leg of the bent links
    localparam box_t linkBoxB [linkCount] = '{
        unusedBox,
        unusedBox,
        '{10'd467, 10'd497, 10'd154, 10'd185},
        unusedBox,
        unusedBox,
        unusedBox,
        '{10'd520, 10'd525, 10'd229, 10'd236},
        unusedBox,
        unusedBox,
        unusedBox,
        unusedBox,
        '{10'd480, 10'd496, 10'd298, 10'd307},
        '{10'd477, 10'd477, 10'd299, 10'd300},
        unusedBox,
        unusedBox,
        '{10'd420, 10'd420, 10'd342, 10'd354}
    };

    localparam routeMask_t linkBoxBUsed = 16'b1001_1000_0100_0100;   // Links 2, 6, 11, 12, 15

    // ------------------------------
    // Panel regions
    // ------------------------------
    localparam box_t labelBox  = '{10'd300, 10'd398, 10'd0, 10'd20};
    localparam box_t digit1Box = '{10'd0,   10'd14,  10'd0, 10'd19};
    localparam box_t digit2Box = '{10'd20,  10'd34,  10'd0, 10'd19};

    function automatic logic inBox(coord_t x, coord_t y, box_t box);
        return (x >= box.xLo) && (x <= box.xHi) && (y >= box.yLo) && (y <= box.yHi);
    endfunction

    // Square window around a centre, safe near the screen edge
    function automatic logic nearPoint(coord_t x, coord_t y, coord_t cx, coord_t cy,
                                       coord_t radius);
        coord_t dx;
        coord_t dy;
        dx = (x >= cx) ? x - cx : cx - x;
        dy = (y >= cy) ? y - cy : cy - y;
        return (dx <= radius) && (dy <= radius);
    endfunction

endpackage

/* pixelColorPkg.sv */
/*
 * Pixel colour types.
 * Tile classes, the pixel request carried through the
 * pipeline and the palette of the map display.
 */
package pixelColorPkg;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // Class given by the map renderer
    typedef enum logic [1:0] {
        tileMarker = 2'd0,
        tilePlain  = 2'd1,
        tileRail   = 2'd2,
        tilePanel  = 2'd3
    } tileClass_t;

    typedef struct packed {
        mapGeometryPkg::coord_t drawX;
        mapGeometryPkg::coord_t drawY;
        tileClass_t             tileClass;
        logic                   cityName;   // Glyph bit of the city label
        logic                   digit1;
        logic                   digit2;
    } pixelReq_t;

    // ------------------------------
    // Base colours per class
    // ------------------------------
    localparam rgb_t markerBase = '{8'd0,   8'd0,   8'd0};
    localparam rgb_t plainBase  = '{8'd255, 8'd255, 8'd255};
    localparam rgb_t railBase   = '{8'd85,  8'd109, 8'd75};
    localparam rgb_t panelBase  = '{8'd255, 8'd195, 8'd195};

    // ------------------------------
    // Overlay colours
    // ------------------------------
    localparam rgb_t routeColor  = '{8'd0,   8'd0,   8'd255};
    localparam rgb_t beginColor  = '{8'd255, 8'd0,   8'd0};
    localparam rgb_t endColor    = '{8'd0,   8'd255, 8'd255};
    localparam rgb_t textColor   = '{8'd222, 8'd12,  8'd12};
    localparam rgb_t cursorColor = '{8'd255, 8'd215, 8'd0};   // Mouse pointer, beats all

endpackage

/* stationLocator.sv */
/*
 * Station locator.
 * Turns the mouse cursor position into a registered station index.
 */
`timescale 1ns/10ps

module stationLocator (
    input  logic                       Clk,
    input  logic                       reset,
    input  mapGeometryPkg::coord_t     cursorX,
    input  mapGeometryPkg::coord_t     cursorY,
    output mapGeometryPkg::stationId_t stationId
);
    import mapGeometryPkg::*;

    stationId_t hitId;

    // Later stations override earlier ones, so the highest index wins
    always_comb
    begin
        hitId = '0;
        for (int i = 1; i <= stationCount; i++)
        begin
            if (nearPoint(cursorX, cursorY, stationX[i], stationY[i], pickRadius))
                hitId = stationId_t'(i);
        end
    end

    always_ff @(posedge Clk)
    begin
        if (reset)
            stationId <= '0;
        else
            stationId <= hitId;
    end

    // Index must stay inside the station table used downstream
    idInRange: assert property (@(posedge Clk) disable iff (reset)
        stationId <= stationId_t'(stationCount));

endmodule

/* routeOverlay.sv */
/*
 * Route overlay, stage 1.
 * Flags pixels that fall on a rail link enabled in the route mask.
 * Tile class is not looked at here.
 */
`timescale 1ns/10ps

module routeOverlay (
    input  logic                       Clk,
    input  logic                       reset,
    input  pixelColorPkg::pixelReq_t   pixReq,
    input  mapGeometryPkg::routeMask_t routeMask,
    output logic                       routeHit
);
    import mapGeometryPkg::*;

    routeMask_t linkHit;
    logic       anyHit;

    // ------------------------------
    // Per-link box test
    // ------------------------------
    always_comb
    begin
        for (int k = 0; k < linkCount; k++)
        begin
            linkHit[k] = inBox(pixReq.drawX, pixReq.drawY, linkBoxA[k])
                       | (linkBoxBUsed[k] & inBox(pixReq.drawX, pixReq.drawY, linkBoxB[k]));
        end
    end

    assign anyHit = |(linkHit & routeMask);   // Only links on the current route

    always_ff @(posedge Clk)
    begin
        if (reset)
            routeHit <= 1'b0;
        else
            routeHit <= anyHit;
    end

endmodule

/* markerOverlay.sv */
/*
 * Marker overlay, stage 1.
 * Flags pixels inside the square markers of the begin and end stations.
 */
`timescale 1ns/10ps

module markerOverlay (
    input  logic                       Clk,
    input  logic                       reset,
    input  pixelColorPkg::pixelReq_t   pixReq,
    input  mapGeometryPkg::stationId_t beginId,
    input  mapGeometryPkg::stationId_t endId,
    output logic                       beginHit,
    output logic                       endHit
);
    import mapGeometryPkg::*;

    logic beginNear;
    logic endNear;

    // Id 0 means no station picked
    function automatic logic onMarker(stationId_t id, coord_t x, coord_t y);
        logic hit;
        hit = 1'b0;
        if (id != '0 && id <= stationId_t'(stationCount))
            hit = nearPoint(x, y, stationX[id], stationY[id], markerRadius);
        return hit;
    endfunction

    assign beginNear = onMarker(beginId, pixReq.drawX, pixReq.drawY);
    assign endNear   = onMarker(endId, pixReq.drawX, pixReq.drawY);

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            beginHit <= 1'b0;
            endHit   <= 1'b0;
        end
        else
        begin
            beginHit <= beginNear;
            endHit   <= endNear;
        end
    end

    // Route endpoints come from outside and must name real stations
    idsInRange: assert property (@(posedge Clk) disable iff (reset)
        beginId <= stationId_t'(stationCount) && endId <= stationId_t'(stationCount));

endmodule

/* pixelColorizer.sv */
/*
 * Pixel colorizer.
 * Holds the pixel for one cycle while the overlays look at it,
 * then picks the final colour in the second stage.
 */
`timescale 1ns/10ps

module pixelColorizer (
    input  logic                       Clk,
    input  logic                       reset,
    input  logic                       pixelValid,
    input  pixelColorPkg::pixelReq_t   pixReq,
    input  logic                       isCursor,
    input  logic                       routeHit,
    input  logic                       beginHit,
    input  logic                       endHit,
    input  mapGeometryPkg::stationId_t stationId,
    output pixelColorPkg::rgb_t        rgb,
    output logic                       rgbValid
);
    import mapGeometryPkg::*;
    import pixelColorPkg::*;

    pixelReq_t reqS1;
    logic      cursorS1;
    logic      validS1;
    logic      textLit;
    rgb_t      nextRgb;

    // ------------------------------
    // Stage 1
    // ------------------------------
    always_ff @(posedge Clk)
    begin
        reqS1    <= pixReq;
        cursorS1 <= isCursor;
    end

    always_ff @(posedge Clk)
    begin
        if (reset)
            validS1 <= 1'b0;
        else
            validS1 <= pixelValid;
    end

    // ------------------------------
    // Stage 2
    // ------------------------------
    // City label needs a hovered station as well as the glyph bit
    assign textLit = (inBox(reqS1.drawX, reqS1.drawY, labelBox) && reqS1.cityName
                      && stationId != '0)
                   || (inBox(reqS1.drawX, reqS1.drawY, digit1Box) && reqS1.digit1)
                   || (inBox(reqS1.drawX, reqS1.drawY, digit2Box) && reqS1.digit2);

    always_comb
    begin
        nextRgb = cursorColor;
        if (!cursorS1)
        begin
            case (reqS1.tileClass)
                tileMarker:
                begin
                    nextRgb = markerBase;
                    if (beginHit)
                        nextRgb = beginColor;
                    if (endHit)
                        nextRgb = endColor;   // End marker drawn on top
                end
                tilePlain:
                    nextRgb = plainBase;
                tileRail:
                    nextRgb = routeHit ? routeColor : railBase;
                tilePanel:
                    nextRgb = textLit ? textColor : panelBase;
                default:
                    nextRgb = plainBase;
            endcase
        end
    end

    always_ff @(posedge Clk)
    begin
        rgb <= nextRgb;
    end

    always_ff @(posedge Clk)
    begin
        if (reset)
            rgbValid <= 1'b0;
        else
            rgbValid <= validS1;
    end

    // Fixed two-cycle latency, broken only by a reset inside the window
    latencyTwo: assert property (@(posedge Clk) disable iff (reset)
        rgbValid == ($past(pixelValid, 2) && !$past(reset, 1) && !$past(reset, 2)));

endmodule

/* colorMapper.sv */
/*
 * Colour mapper top level.
 * Two-stage pixel colour pipeline with the station locator beside it.
 */
`timescale 1ns/10ps

module colorMapper (
    input  logic                       Clk,
    input  logic                       reset,
    input  logic                       pixelValid,
    input  pixelColorPkg::pixelReq_t   pixReq,
    input  logic                       isCursor,
    input  mapGeometryPkg::routeMask_t routeMask,
    input  mapGeometryPkg::stationId_t beginId,
    input  mapGeometryPkg::stationId_t endId,
    input  mapGeometryPkg::coord_t     cursorX,
    input  mapGeometryPkg::coord_t     cursorY,
    output pixelColorPkg::rgb_t        rgb,
    output logic                       rgbValid,
    output mapGeometryPkg::stationId_t stationId
);
    // Stage 1 overlay flags
    logic routeHit;
    logic beginHit;
    logic endHit;

    stationLocator stationLocator_inst (
        .Clk       (Clk),
        .reset     (reset),
        .cursorX   (cursorX),
        .cursorY   (cursorY),
        .stationId (stationId)
    );

    routeOverlay routeOverlay_inst (
        .Clk       (Clk),
        .reset     (reset),
        .pixReq    (pixReq),
        .routeMask (routeMask),
        .routeHit  (routeHit)
    );

    markerOverlay markerOverlay_inst (
        .Clk      (Clk),
        .reset    (reset),
        .pixReq   (pixReq),
        .beginId  (beginId),
        .endId    (endId),
        .beginHit (beginHit),
        .endHit   (endHit)
    );

    pixelColorizer pixelColorizer_inst (
        .Clk        (Clk),
        .reset      (reset),
        .pixelValid (pixelValid),
        .pixReq     (pixReq),
        .isCursor   (isCursor),
        .routeHit   (routeHit),
        .beginHit   (beginHit),
        .endHit     (endHit),
        .stationId  (stationId),   // Label test in stage 2
        .rgb        (rgb),
        .rgbValid   (rgbValid)
    );

endmodule

/* tbClockGen.sv */
/*
 * Testbench clock source with a 100 ns period.
 */
`timescale 1ns/10ps

module tbClockGen (
    output logic Clk
);
    localparam int halfPeriod = 50;   // ns

    initial
    begin
        Clk = 1'b0;
        forever
            #halfPeriod Clk = ~Clk;
    end

endmodule

/* colorMapperTb.sv */
/*
 * Colour mapper testbench.
 * Directed tests of pipeline timing, palette, overlays and station lookup.
 */
`timescale 1ns/10ps

module colorMapperTb;
    import mapGeometryPkg::*;
    import pixelColorPkg::*;

    localparam int         waitLimit      = 8;         // Cycles allowed for rgbValid
    localparam coord_t     farX           = 10'd100;   // Clear of every overlay
    localparam coord_t     farY           = 10'd450;
    localparam tileClass_t allClasses [4] = '{tileMarker, tilePlain, tileRail, tilePanel};
    localparam rgb_t       classBase [4]  = '{markerBase, plainBase, railBase, panelBase};

    logic       Clk, reset, pixelValid, isCursor, rgbValid;
    pixelReq_t  pixReq;
    routeMask_t routeMask;
    stationId_t beginId, endId, stationId;
    coord_t     cursorX, cursorY;
    rgb_t       rgb;

    tbClockGen tbClockGen_inst (.Clk(Clk));
    colorMapper colorMapper_inst (.*);

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    function automatic pixelReq_t makeReq(coord_t x, coord_t y, tileClass_t cls,
                                          logic [2:0] glyphs);
        return '{x, y, cls, glyphs[2], glyphs[1], glyphs[0]};   // cityName, digit1, digit2
    endfunction

    // Random point inside a box
    function automatic pixelReq_t randReq(box_t box, tileClass_t cls, logic [2:0] glyphs);
        return makeReq(coord_t'($urandom_range(int'(box.xHi), int'(box.xLo))),
                       coord_t'($urandom_range(int'(box.yHi), int'(box.yLo))), cls, glyphs);
    endfunction

    task automatic checkRgb(input string testName, input rgb_t expected);
        assert (rgb === expected)
        else
            abortRun($sformatf("Mismatch in %s: expected %h, actual %h",
                               testName, expected, rgb));
    endtask

    // One pixel in, then wait for its colour
    task automatic sendPixel(input string testName, input pixelReq_t req,
                             input logic cursor, input rgb_t expected);
        int waited;
        @(negedge Clk);
        pixelValid = 1'b1;
        pixReq     = req;
        isCursor   = cursor;
        @(negedge Clk);
        pixelValid = 1'b0;
        waited     = 0;
        while (!rgbValid && waited < waitLimit)
        begin
            @(negedge Clk);
            waited++;
        end
        assert (rgbValid)
        else
            abortRun($sformatf("Timeout in %s: no rgbValid after the pixel", testName));
        checkRgb(testName, expected);
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    // Idle pipeline, then one pixel of each class back to back
    task automatic pipelineTiming();
        logic want;
        routeMask = '1;
        beginId   = 5'd1;
        endId     = 5'd2;
        for (int c = 0; c < 10; c++)
        begin
            @(negedge Clk);
            want = (c >= 5) && (c <= 8);   // Two cycles after driving
            assert (rgbValid === want)
            else
                abortRun($sformatf("Mismatch in pipeline cycle %0d: expected rgbValid %b, actual %b",
                                   c, want, rgbValid));
            if (want)
                checkRgb("pipeline base colour", classBase[c - 5]);
            pixelValid = (c >= 3) && (c <= 6);
            pixReq     = makeReq(farX, farY, allClasses[(c + 1) % 4], 3'b111);
        end
        pixelValid = 1'b0;
    endtask

    // Each link box on rail and plain tiles
    task automatic routeOverlays();
        pixelReq_t req;
        beginId = '0;
        endId   = '0;
        for (int k = 0; k < linkCount; k++)
        begin
            req       = randReq(linkBoxA[k], tileRail, 3'b000);
            routeMask = 16'd1 << k;
            sendPixel($sformatf("route link %0d", k), req, 1'b0, routeColor);
            routeMask = '0;
            sendPixel($sformatf("idle link %0d", k), req, 1'b0, railBase);
            routeMask     = '1;
            req.tileClass = tilePlain;
            sendPixel($sformatf("plain tile on link %0d", k), req, 1'b0, plainBase);
        end
        routeMask = 16'd1 << 2;   // Bent leg of link 2
        sendPixel("route bend", randReq(linkBoxB[2], tileRail, 3'b000), 1'b0, routeColor);
        routeMask = '1;   // Origin lies inside every unused second box
        sendPixel("unused leg at origin", makeReq(10'd0, 10'd0, tileRail, 3'b000), 1'b0,
                  railBase);
    endtask

    // Begin and end squares at every station
    task automatic stationMarkers();
        pixelReq_t req;
        routeMask = '0;
        for (int s = 1; s <= stationCount; s++)
        begin
            req     = makeReq(stationX[s], stationY[s], tileMarker, 3'b000);
            beginId = stationId_t'(s);
            endId   = '0;
            sendPixel("begin marker", req, 1'b0, beginColor);
            endId = stationId_t'(s);
            sendPixel("end over begin", req, 1'b0, endColor);
            beginId   = '0;
            req.drawX = stationX[s] + 10'd1;   // Corner of the square
            req.drawY = stationY[s] - 10'd1;
            sendPixel("end marker corner", req, 1'b0, endColor);
            endId = '0;
            sendPixel("no station picked", req, 1'b0, markerBase);
        end
    endtask

    // Locator on every station, then label and digit glyphs
    task automatic panelGlyphs();
        pixelReq_t label;
        label = randReq(labelBox, tilePanel, 3'b100);
        for (int s = 0; s <= stationCount; s++)
        begin
            cursorX = (s == 0) ? 10'd0 : stationX[s];   // Top left is off every station
            cursorY = (s == 0) ? 10'd0 : stationY[s];
            @(negedge Clk);   // Locator output is one register deep
            assert (stationId === stationId_t'(s))
            else
                abortRun($sformatf("Mismatch in station lookup: expected %0d, actual %0d",
                                   s, stationId));
            sendPixel($sformatf("label for station %0d", s), label, 1'b0,
                      (s == 0) ? panelBase : textColor);
        end
        label.cityName = 1'b0;   // Station 16 still hovered
        sendPixel("label without glyph", label, 1'b0, panelBase);
        sendPixel("digit 1", randReq(digit1Box, tilePanel, 3'b010), 1'b0, textColor);
        sendPixel("digit 1 blank", randReq(digit1Box, tilePanel, 3'b101), 1'b0, panelBase);
        sendPixel("digit 2", randReq(digit2Box, tilePanel, 3'b001), 1'b0, textColor);
        sendPixel("digit 2 blank", randReq(digit2Box, tilePanel, 3'b110), 1'b0, panelBase);
    endtask

    // Cursor beats every class and overlay
    task automatic cursorOverride();
        routeMask = '1;
        beginId   = 5'd9;
        endId     = 5'd9;
        for (int c = 0; c < 4; c++)
        begin
            sendPixel("cursor on marker",
                      makeReq(stationX[9], stationY[9], allClasses[c], 3'b111),
                      1'b1, cursorColor);
            sendPixel("cursor on route", randReq(linkBoxA[7], allClasses[c], 3'b111),
                      1'b1, cursorColor);
            sendPixel("cursor on label", randReq(labelBox, allClasses[c], 3'b111),
                      1'b1, cursorColor);
        end
    endtask

    initial
    begin
        void'($urandom(45));
        reset      = 1'b1;
        pixelValid = 1'b0;
        pixReq     = '0;
        isCursor   = 1'b0;
        routeMask  = '0;
        beginId    = '0;
        endId      = '0;
        cursorX    = '0;
        cursorY    = '0;
        repeat (3) @(posedge Clk);   // Three reset cycles
        @(negedge Clk);
        reset = 1'b0;
        pipelineTiming();
        routeOverlays();
        stationMarkers();
        panelGlyphs();
        cursorOverride();
        $display("TEST OK");
        $finish;
    end

endmodule

/* colorMapper.f */
mapGeometryPkg.sv
pixelColorPkg.sv
stationLocator.sv
routeOverlay.sv
markerOverlay.sv
pixelColorizer.sv
colorMapper.sv
tbClockGen.sv
colorMapperTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Build the colour mapper testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module colorMapperTb -f colorMapper.f \
    && ./obj_dir/VcolorMapperTb \
    || exit 1
